//--- design/conv1x1_pkg.sv
`default_nettype none

package conv1x1_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////////////////////

    // Pixel, weight, bias and result width
    localparam int PIXEL_W = 16;
    // Lanes per input word and per weight word
    localparam int SIMD = 8;

    ////////////////////////////////////////////////////////////////////////////
    // Memory sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int WGT_DEPTH = 64;
    localparam int BIAS_DEPTH = 16;
    localparam int WGT_ADDR_W = $clog2(WGT_DEPTH);
    localparam int BIAS_ADDR_W = $clog2(BIAS_DEPTH);

    // Depth and kernel-count config fields
    localparam int CFG_W = 8;

    ////////////////////////////////////////////////////////////////////////////
    // Stage latencies
    ////////////////////////////////////////////////////////////////////////////

    // Operand register plus product register
    localparam int MULT_LAT = 2;
    // One register level per halving step
    localparam int TREE_LAT = $clog2(SIMD);

    // Vector types
    typedef logic [PIXEL_W-1:0] pixel_t;
    // Lane 0 sits in the low bits
    typedef logic [SIMD*PIXEL_W-1:0] pix_vec_t;
    typedef logic [WGT_ADDR_W-1:0] wgt_addr_t;
    typedef logic [BIAS_ADDR_W-1:0] bias_addr_t;
    typedef logic [CFG_W-1:0] cfg_cnt_t;

endpackage

`default_nettype wire

//--- design/kernel_ram.sv
`default_nettype none

module kernel_ram #(
    parameter int DEPTH = 64,
    parameter int WIDTH = 128
) (
    input  wire                       clk_FAS,
    input  wire                       rst_n,
    input  wire                       clr,
    input  wire                       wr_en,
    input  wire [WIDTH-1:0]           wr_data,
    input  wire [$clog2(DEPTH)-1:0]   rd_addr,
    output logic [WIDTH-1:0]          rd_data
);

    // Storage array
    logic [WIDTH-1:0] mem [DEPTH];

    // Next entry to be loaded
    logic [$clog2(DEPTH)-1:0] wr_ptr;

    ////////////////////////////////////////////////////////////////////////////
    // Write pointer
    ////////////////////////////////////////////////////////////////////////////

    // Steps once per loaded entry
    // Back to zero on job clear
    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (clr) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            // Wrap after the top entry
            if (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Array access
    ////////////////////////////////////////////////////////////////////////////

    // Synchronous write port
    // Registered read port, data one cycle after address
    always_ff @(posedge clk_FAS) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- design/conv1x1_seq.sv
`default_nettype none

module conv1x1_seq (
    input  wire                           clk_FAS,
    input  wire                           rst_n,
    input  wire                           job_clr,
    input  wire                           pix_vld,
    input  wire conv1x1_pkg::pix_vec_t    pix_data,
    input  wire conv1x1_pkg::cfg_cnt_t    cfg_depth_words,
    input  wire conv1x1_pkg::cfg_cnt_t    cfg_num_kernels,
    output conv1x1_pkg::wgt_addr_t        wgt_rd_addr,
    output conv1x1_pkg::bias_addr_t       bias_rd_addr,
    output conv1x1_pkg::pix_vec_t         pix_d,
    output logic                          seq_vld,
    output logic                          seq_last
);

    import conv1x1_pkg::*;

    // Word index inside current kernel
    cfg_cnt_t dpth_cnt;
    // Kernel index of the word being accepted
    cfg_cnt_t krnl_cnt;
    wgt_addr_t wgt_addr;
    // Kernel index travelling beside the word
    bias_addr_t bias_pipe [MULT_LAT + TREE_LAT];

    logic last_word;
    logic last_krnl;

    // End of kernel depth and end of kernel list
    assign last_word = (dpth_cnt == cfg_depth_words - cfg_cnt_t'(1));
    assign last_krnl = (krnl_cnt == cfg_num_kernels - cfg_cnt_t'(1));

    // RAM samples this on the accepting edge
    assign wgt_rd_addr = wgt_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Depth, kernel and weight address counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            dpth_cnt <= '0;
            krnl_cnt <= '0;
            wgt_addr <= '0;
        end else if (job_clr) begin
            dpth_cnt <= '0;
            krnl_cnt <= '0;
            wgt_addr <= '0;
        end else if (pix_vld) begin
            if (!last_word) begin
                dpth_cnt <= dpth_cnt + cfg_cnt_t'(1);
                wgt_addr <= wgt_addr + 1'b1;
            end else if (!last_krnl) begin
                // Next kernel, weights continue linearly
                dpth_cnt <= '0;
                krnl_cnt <= krnl_cnt + cfg_cnt_t'(1);
                wgt_addr <= wgt_addr + 1'b1;
            end else begin
                // Whole job done, restart from weight 0
                dpth_cnt <= '0;
                krnl_cnt <= '0;
                wgt_addr <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word register, lines up with weight read data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            pix_d <= '0;
            seq_vld <= 1'b0;
            seq_last <= 1'b0;
        end else begin
            seq_vld <= pix_vld;
            seq_last <= pix_vld & last_word;
            if (pix_vld) begin
                pix_d <= pix_data;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bias address
    ////////////////////////////////////////////////////////////////////////////

    // Stage 0 holds kernel of the registered word
    // Last stage addresses the bias RAM one cycle before the tree sum lands
    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MULT_LAT + TREE_LAT; i++) begin
                bias_pipe[i] <= '0;
            end
        end else if (job_clr) begin
            for (int i = 0; i < MULT_LAT + TREE_LAT; i++) begin
                bias_pipe[i] <= '0;
            end
        end else begin
            if (pix_vld) begin
                bias_pipe[0] <= krnl_cnt[BIAS_ADDR_W-1:0];
            end
            for (int i = 1; i < MULT_LAT + TREE_LAT; i++) begin
                bias_pipe[i] <= bias_pipe[i-1];
            end
        end
    end

    assign bias_rd_addr = bias_pipe[MULT_LAT + TREE_LAT - 1];

endmodule

`default_nettype wire

//--- design/vec_mult.sv
`default_nettype none

module vec_mult (
    input  wire                           clk_FAS,
    input  wire                           rst_n,
    input  wire conv1x1_pkg::pix_vec_t    pix_d,
    input  wire conv1x1_pkg::pix_vec_t    wgt,
    input  wire                           in_vld,
    input  wire                           in_last,
    output conv1x1_pkg::pix_vec_t         prod_vec,
    output logic                          prod_vld,
    output logic                          prod_last
);

    import conv1x1_pkg::*;

    // Operand stage
    pix_vec_t pix_q;
    pix_vec_t wgt_q;
    logic vld_q;
    logic last_q;

    // Lane products before the output register
    pix_vec_t prod_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            pix_q <= '0;
            wgt_q <= '0;
            vld_q <= 1'b0;
            last_q <= 1'b0;
        end else begin
            pix_q <= pix_d;
            wgt_q <= wgt;
            vld_q <= in_vld;
            last_q <= in_vld & in_last;
        end
    end

    // Low PIXEL_W bits of each lane product
    // Same bits for signed and unsigned operands
    always_comb begin
        for (int i = 0; i < SIMD; i++) begin
            prod_nxt[i*PIXEL_W +: PIXEL_W] =
                pix_q[i*PIXEL_W +: PIXEL_W] * wgt_q[i*PIXEL_W +: PIXEL_W];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            prod_vec <= '0;
            prod_vld <= 1'b0;
            prod_last <= 1'b0;
        end else begin
            prod_vec <= prod_nxt;
            prod_vld <= vld_q;
            prod_last <= last_q;
        end
    end

endmodule

`default_nettype wire

//--- design/adder_tree.sv
`default_nettype none

module adder_tree (
    input  wire                           clk_FAS,
    input  wire                           rst_n,
    input  wire conv1x1_pkg::pix_vec_t    prod_vec,
    input  wire                           in_vld,
    input  wire                           in_last,
    output conv1x1_pkg::pixel_t           sum,
    output logic                          sum_vld,
    output logic                          sum_last
);

    import conv1x1_pkg::*;

    // Partial sums per level
    pixel_t lvl1 [SIMD/2];
    pixel_t lvl2 [SIMD/4];

    // Flags beside each level
    logic vld1;
    logic vld2;
    logic last1;
    logic last2;

    ////////////////////////////////////////////////////////////////////////////
    // Level 1, lane pairs
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SIMD/2; i++) begin
                lvl1[i] <= '0;
            end
            vld1 <= 1'b0;
            last1 <= 1'b0;
        end else begin
            // Neighbouring lanes 2i and 2i+1
            for (int i = 0; i < SIMD/2; i++) begin
                lvl1[i] <= prod_vec[2*i*PIXEL_W +: PIXEL_W]
                         + prod_vec[(2*i+1)*PIXEL_W +: PIXEL_W];
            end
            vld1 <= in_vld;
            last1 <= in_vld & in_last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Level 2
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SIMD/4; i++) begin
                lvl2[i] <= '0;
            end
            vld2 <= 1'b0;
            last2 <= 1'b0;
        end else begin
            for (int i = 0; i < SIMD/4; i++) begin
                lvl2[i] <= lvl1[2*i] + lvl1[2*i+1];
            end
            vld2 <= vld1;
            last2 <= last1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Level 3, final sum
    ////////////////////////////////////////////////////////////////////////////

    // Wraps modulo 2^PIXEL_W like every stage before it
    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
            sum_vld <= 1'b0;
            sum_last <= 1'b0;
        end else begin
            sum <= lvl2[0] + lvl2[1];
            sum_vld <= vld2;
            sum_last <= last2;
        end
    end

endmodule

`default_nettype wire

//--- design/depth_accum.sv
`default_nettype none

module depth_accum (
    input  wire                           clk_FAS,
    input  wire                           rst_n,
    input  wire                           job_clr,
    input  wire conv1x1_pkg::pixel_t      sum,
    input  wire                           sum_vld,
    input  wire                           sum_last,
    input  wire conv1x1_pkg::pixel_t      bias,
    input  wire                           cfg_bias_en,
    output conv1x1_pkg::pixel_t           out_pixel,
    output logic                          out_vld
);

    import conv1x1_pkg::*;

    // Running total over the depth of one kernel
    pixel_t acc;
    // Bias term, zero when disabled
    pixel_t bias_sel;
    // Total including the current sum
    pixel_t acc_nxt;

    assign bias_sel = cfg_bias_en ? bias : '0;
    assign acc_nxt = acc + sum;

    ////////////////////////////////////////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////////////////////////////////////////

    // Restart from zero after each kernel
    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (job_clr) begin
            acc <= '0;
        end else if (sum_vld) begin
            if (sum_last) begin
                acc <= '0;
            end else begin
                acc <= acc_nxt;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    // One pulse per kernel, on its last depth word
    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            out_pixel <= '0;
            out_vld <= 1'b0;
        end else begin
            out_vld <= sum_vld & sum_last;
            if (sum_vld && sum_last) begin
                // Bias RAM output already points at this kernel
                out_pixel <= acc_nxt + bias_sel;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/conv1x1_pip.sv
`default_nettype none

module conv1x1_pip (
    input  wire                           clk_FAS,
    input  wire                           rst_n,
    input  wire                           job_clr,
    // Weight load
    input  wire                           wgt_wr_en,
    input  wire conv1x1_pkg::pix_vec_t    wgt_wr_data,
    // Bias load
    input  wire                           bias_wr_en,
    input  wire conv1x1_pkg::pixel_t      bias_wr_data,
    // Pixel stream
    input  wire                           pix_vld,
    input  wire conv1x1_pkg::pix_vec_t    pix_data,
    // Job config, stable while running
    input  wire conv1x1_pkg::cfg_cnt_t    cfg_depth_words,
    input  wire conv1x1_pkg::cfg_cnt_t    cfg_num_kernels,
    input  wire                           cfg_bias_en,
    // One pixel per kernel
    output conv1x1_pkg::pixel_t           out_pixel,
    output logic                          out_vld
);

    import conv1x1_pkg::*;

    // Sequencer to memories and multiplier
    wgt_addr_t wgt_rd_addr;
    bias_addr_t bias_rd_addr;
    pix_vec_t pix_d;
    logic seq_vld;
    logic seq_last;

    // Memory read data
    pix_vec_t wgt_rd_data;
    pixel_t bias_rd_data;

    // Multiplier to adder tree
    pix_vec_t prod_vec;
    logic prod_vld;
    logic prod_last;

    // Adder tree to accumulator
    pixel_t sum;
    logic sum_vld;
    logic sum_last;

    ////////////////////////////////////////////////////////////////////////////
    // Read sequencing
    ////////////////////////////////////////////////////////////////////////////

    conv1x1_seq seq_i (
        .clk_FAS         (clk_FAS),
        .rst_n           (rst_n),
        .job_clr         (job_clr),
        .pix_vld         (pix_vld),
        .pix_data        (pix_data),
        .cfg_depth_words (cfg_depth_words),
        .cfg_num_kernels (cfg_num_kernels),
        .wgt_rd_addr     (wgt_rd_addr),
        .bias_rd_addr    (bias_rd_addr),
        .pix_d           (pix_d),
        .seq_vld         (seq_vld),
        .seq_last        (seq_last)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Kernel memories
    ////////////////////////////////////////////////////////////////////////////

    // One SIMD weight word per entry
    kernel_ram #(
        .DEPTH (WGT_DEPTH),
        .WIDTH (SIMD * PIXEL_W)
    ) wgt_ram_i (
        .clk_FAS (clk_FAS),
        .rst_n   (rst_n),
        .clr     (job_clr),
        .wr_en   (wgt_wr_en),
        .wr_data (wgt_wr_data),
        .rd_addr (wgt_rd_addr),
        .rd_data (wgt_rd_data)
    );

    // One bias per kernel
    kernel_ram #(
        .DEPTH (BIAS_DEPTH),
        .WIDTH (PIXEL_W)
    ) bias_ram_i (
        .clk_FAS (clk_FAS),
        .rst_n   (rst_n),
        .clr     (job_clr),
        .wr_en   (bias_wr_en),
        .wr_data (bias_wr_data),
        .rd_addr (bias_rd_addr),
        .rd_data (bias_rd_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Arithmetic pipeline
    ////////////////////////////////////////////////////////////////////////////

    vec_mult mult_i (
        .clk_FAS   (clk_FAS),
        .rst_n     (rst_n),
        .pix_d     (pix_d),
        .wgt       (wgt_rd_data),
        .in_vld    (seq_vld),
        .in_last   (seq_last),
        .prod_vec  (prod_vec),
        .prod_vld  (prod_vld),
        .prod_last (prod_last)
    );

    adder_tree tree_i (
        .clk_FAS  (clk_FAS),
        .rst_n    (rst_n),
        .prod_vec (prod_vec),
        .in_vld   (prod_vld),
        .in_last  (prod_last),
        .sum      (sum),
        .sum_vld  (sum_vld),
        .sum_last (sum_last)
    );

    depth_accum accum_i (
        .clk_FAS     (clk_FAS),
        .rst_n       (rst_n),
        .job_clr     (job_clr),
        .sum         (sum),
        .sum_vld     (sum_vld),
        .sum_last    (sum_last),
        .bias        (bias_rd_data),
        .cfg_bias_en (cfg_bias_en),
        .out_pixel   (out_pixel),
        .out_vld     (out_vld)
    );

endmodule

`default_nettype wire

//--- verification/tb_conv1x1.sv
`default_nettype none

module tb_conv1x1;

    import conv1x1_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Run limits
    ////////////////////////////////////////////////////////////////////////////

    localparam int CLK_PERIOD = 40;
    localparam int SEED = 32'h5b95_9774;
    localparam int NUM_TESTS = 5;
    // Load words plus stream words, summed over the tests
    localparam int TOTAL_WORDS = 2 + 27 + 24 + 25;
    // Covers reset, idle window, gaps and drains
    localparam int MARGIN = 400;
    localparam int WDOG_TIME = (TOTAL_WORDS + 7 * NUM_TESTS + MARGIN) * CLK_PERIOD;
    // Pixel to out_vld, in cycles
    localparam int PIPE_LAT = 7;

    // DUT ports
    logic clk_FAS;
    logic rst_n;
    logic job_clr;
    logic wgt_wr_en;
    pix_vec_t wgt_wr_data;
    logic bias_wr_en;
    pixel_t bias_wr_data;
    logic pix_vld;
    pix_vec_t pix_data;
    cfg_cnt_t cfg_depth_words;
    cfg_cnt_t cfg_num_kernels;
    logic cfg_bias_en;
    pixel_t out_pixel;
    logic out_vld;

    // Shadow copies of both memories and their load pointers
    pix_vec_t ref_wgt [WGT_DEPTH];
    pixel_t ref_bias [BIAS_DEPTH];
    int ref_wptr;
    int ref_bptr;

    // Words of the current pass, expected and captured results
    pix_vec_t sent_q [$];
    pixel_t exp_q [$];
    pixel_t got_pix [$];
    int got_cyc [$];

    int cyc = 0;
    int last_drive_cyc;
    int err_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int unsigned seed_val;

    conv1x1_pip dut_i (
        .clk_FAS         (clk_FAS),
        .rst_n           (rst_n),
        .job_clr         (job_clr),
        .wgt_wr_en       (wgt_wr_en),
        .wgt_wr_data     (wgt_wr_data),
        .bias_wr_en      (bias_wr_en),
        .bias_wr_data    (bias_wr_data),
        .pix_vld         (pix_vld),
        .pix_data        (pix_data),
        .cfg_depth_words (cfg_depth_words),
        .cfg_num_kernels (cfg_num_kernels),
        .cfg_bias_en     (cfg_bias_en),
        .out_pixel       (out_pixel),
        .out_vld         (out_vld)
    );

    initial clk_FAS = 1'b0;
    always #(CLK_PERIOD / 2) clk_FAS = ~clk_FAS;

    // Capture each result with the cycle in which out_vld was high
    always @(posedge clk_FAS) begin
        cyc <= cyc + 1;
        if (out_vld) begin
            got_pix.push_back(out_pixel);
            got_cyc.push_back(cyc - 1);
        end
    end

    // Watchdog
    initial begin
        #(WDOG_TIME);
        $display("Timeout: run did not finish within %0d time units", WDOG_TIME);
        $display("Testbench failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic pix_vec_t rand_vec();
        pix_vec_t v;
        for (int i = 0; i < SIMD; i++) begin
            v[i*PIXEL_W +: PIXEL_W] = pixel_t'($urandom());
        end
        return v;
    endfunction

    // Lane products and their sum, all modulo 2^16
    function automatic pixel_t lane_dot(input pix_vec_t a, input pix_vec_t b);
        pixel_t s;
        pixel_t p;
        s = '0;
        for (int i = 0; i < SIMD; i++) begin
            p = a[i*PIXEL_W +: PIXEL_W] * b[i*PIXEL_W +: PIXEL_W];
            s = s + p;
        end
        return s;
    endfunction

    // One pass restarts at weight 0, kernel k uses bias k
    task automatic compute_expected(input int depth, input int kernels, input bit bias_en);
        pixel_t acc;
        int w;
        for (int k = 0; k < kernels; k++) begin
            acc = '0;
            for (int d = 0; d < depth; d++) begin
                w = k * depth + d;
                acc = acc + lane_dot(sent_q[w], ref_wgt[w]);
            end
            if (bias_en) begin
                acc = acc + ref_bias[k];
            end
            exp_q.push_back(acc);
        end
        sent_q.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic clear_job();
        @(posedge clk_FAS);
        job_clr <= 1'b1;
        @(posedge clk_FAS);
        job_clr <= 1'b0;
        ref_wptr = 0;
        ref_bptr = 0;
    endtask

    task automatic load_weights(input int n);
        pix_vec_t w;
        for (int i = 0; i < n; i++) begin
            w = rand_vec();
            @(posedge clk_FAS);
            wgt_wr_en <= 1'b1;
            wgt_wr_data <= w;
            ref_wgt[ref_wptr] = w;
            ref_wptr = (ref_wptr + 1) % WGT_DEPTH;
        end
        @(posedge clk_FAS);
        wgt_wr_en <= 1'b0;
    endtask

    task automatic load_biases(input int n);
        pixel_t b;
        for (int i = 0; i < n; i++) begin
            b = pixel_t'($urandom());
            @(posedge clk_FAS);
            bias_wr_en <= 1'b1;
            bias_wr_data <= b;
            ref_bias[ref_bptr] = b;
            ref_bptr = (ref_bptr + 1) % BIAS_DEPTH;
        end
        @(posedge clk_FAS);
        bias_wr_en <= 1'b0;
    endtask

    task automatic set_config(input int depth, input int kernels, input bit bias_en);
        @(posedge clk_FAS);
        cfg_depth_words <= cfg_cnt_t'(depth);
        cfg_num_kernels <= cfg_cnt_t'(kernels);
        cfg_bias_en <= bias_en;
    endtask

    // Random idle cycles before each word when max_gap is nonzero
    task automatic stream_words(input int n, input int max_gap);
        pix_vec_t w;
        int gap;
        for (int i = 0; i < n; i++) begin
            w = rand_vec();
            sent_q.push_back(w);
            gap = (max_gap > 0) ? int'($urandom() % (max_gap + 1)) : 0;
            repeat (gap) begin
                @(posedge clk_FAS);
                pix_vld <= 1'b0;
            end
            @(posedge clk_FAS);
            pix_vld <= 1'b1;
            pix_data <= w;
            last_drive_cyc = cyc;
        end
        @(posedge clk_FAS);
        pix_vld <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checkers
    ////////////////////////////////////////////////////////////////////////////

    // Bounded wait for n results, then a drain window for extras
    task automatic wait_results(input int n);
        int waited;
        waited = 0;
        while (got_pix.size() < n && waited < 4 * PIPE_LAT) begin
            @(posedge clk_FAS);
            waited++;
        end
        repeat (PIPE_LAT + 3) @(posedge clk_FAS);
        @(negedge clk_FAS);
    endtask

    task automatic check_results();
        int n;
        n = exp_q.size();
        if (got_pix.size() < n) begin
            $display("Missing outputs: got %0d of %0d results", got_pix.size(), n);
            err_cnt++;
        end
        if (got_pix.size() > n) begin
            $display("Extra outputs: got %0d results, expected %0d", got_pix.size(), n);
            err_cnt++;
        end
        for (int i = 0; i < n && i < got_pix.size(); i++) begin
            if (got_pix[i] !== exp_q[i]) begin
                $display("ERR %0t: result %0d is %h, expected %h",
                         $time, i, got_pix[i], exp_q[i]);
                err_cnt++;
            end
        end
        exp_q.delete();
        got_pix.delete();
        got_cyc.delete();
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("PASS  %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL  %s (%0d errors)", name, err_cnt - errs_before);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_idle_test();
        int e0;
        e0 = err_cnt;
        repeat (20) @(posedge clk_FAS);
        @(negedge clk_FAS);
        if (got_pix.size() != 0) begin
            $display("Output pulsed %0d times with no input after reset", got_pix.size());
            err_cnt++;
            got_pix.delete();
            got_cyc.delete();
        end
        report_test("reset idle", e0);
    endtask

    task automatic single_word_test();
        int e0;
        e0 = err_cnt;
        load_weights(1);
        set_config(1, 1, 1'b0);
        stream_words(1, 0);
        compute_expected(1, 1, 1'b0);
        wait_results(1);
        if (got_cyc.size() > 0 && got_cyc[0] != last_drive_cyc + PIPE_LAT) begin
            $display("ERR %0t: result in cycle %0d, expected cycle %0d",
                     $time, got_cyc[0], last_drive_cyc + PIPE_LAT);
            err_cnt++;
        end
        check_results();
        report_test("single word", e0);
    endtask

    task automatic accum_bias_test();
        int e0;
        e0 = err_cnt;
        clear_job();
        load_weights(12);
        load_biases(3);
        set_config(4, 3, 1'b1);
        stream_words(12, 0);
        compute_expected(4, 3, 1'b1);
        wait_results(3);
        check_results();
        report_test("depth accumulate with bias", e0);
    endtask

    // Second pass must start again from weight 0 and bias 0
    task automatic wrap_gap_test();
        int e0;
        e0 = err_cnt;
        for (int p = 0; p < 2; p++) begin
            stream_words(12, 3);
            compute_expected(4, 3, 1'b1);
        end
        wait_results(6);
        check_results();
        report_test("wrap with gaps", e0);
    endtask

    task automatic reload_nobias_test();
        int e0;
        e0 = err_cnt;
        clear_job();
        load_weights(10);
        load_biases(5);
        set_config(2, 5, 1'b0);
        stream_words(10, 1);
        compute_expected(2, 5, 1'b0);
        wait_results(5);
        check_results();
        report_test("reload without bias", e0);
    endtask

    initial begin
        seed_val = $urandom(SEED);
        rst_n <= 1'b0;
        job_clr <= 1'b0;
        wgt_wr_en <= 1'b0;
        wgt_wr_data <= '0;
        bias_wr_en <= 1'b0;
        bias_wr_data <= '0;
        pix_vld <= 1'b0;
        pix_data <= '0;
        cfg_depth_words <= cfg_cnt_t'(1);
        cfg_num_kernels <= cfg_cnt_t'(1);
        cfg_bias_en <= 1'b0;
        ref_wptr = 0;
        ref_bptr = 0;
        repeat (8) @(posedge clk_FAS);
        rst_n <= 1'b1;
        reset_idle_test();
        single_word_test();
        accum_bias_test();
        wrap_gap_test();
        reload_nobias_test();
        $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
design/conv1x1_pkg.sv
design/kernel_ram.sv
design/conv1x1_seq.sv
design/vec_mult.sv
design/adder_tree.sv
design/depth_accum.sv
design/conv1x1_pip.sv
verification/tb_conv1x1.sv
